//--- hdl/ca_stb_pkg.sv
// Alignment strobe position package
// Types for the word and bit selects and the
// decoded strobe location, plus channel word geometry

`default_nettype none

package ca_stb_pkg;

  //////////////////////////////////////////////////
  // Word geometry
  //////////////////////////////////////////////////

  // Bits covered by one selectable word
  localparam int WORD_SPAN = 40;
  // Number of selectable words
  localparam int NUM_WORDS = 8;
  // First location past the last selectable bit
  localparam int STB_LOC_LIMIT = NUM_WORDS * WORD_SPAN;

  //////////////////////////////////////////////////
  // Select and location types
  //////////////////////////////////////////////////

  // One-hot word select, bit k starts at k*WORD_SPAN
  typedef logic [NUM_WORDS-1:0] wd_sel_t;
  // One-hot bit select inside the word
  typedef logic [WORD_SPAN-1:0] bit_sel_t;
  // Strobe bit location in a channel word, 0..319
  typedef logic [8:0] stb_loc_t;
  // Strobe interval and settle count
  typedef logic [7:0] intv_t;

endpackage

`default_nettype wire

//--- hdl/ca_tx_state_pkg.sv
// Transmit alignment state package
// State encoding shared by the strobe control FSM

`default_nettype none

package ca_tx_state_pkg;

  // TX alignment FSM states
  typedef enum logic [2:0]
  {
    // Waiting for link online
    TX_IDLE    = 3'd0,
    // Online, settle timer running
    TX_ONLINE  = 3'd1,
    // Periodic strobe generation
    TX_GEN_STB = 3'd2,
    // Far end recovered, sticky until reset
    TX_DONE    = 3'd3
  } tx_state_e;

endpackage

`default_nettype wire

//--- hdl/ca_tx_strb_ctrl.sv
// TX alignment strobe control
// Detects the online rising edge, runs the settle timer
// and the strobe interval counter, and sequences the
// alignment FSM. Emits a one-cycle strobe pulse every
// tx_stb_intv cycles until the far end reports recovery.

`timescale 1ns/1ps
`default_nettype none

module ca_tx_strb_ctrl
(
  input  wire logic              com_clk,
  input  wire logic              rst_n,
  input  wire logic              tx_online,
  input  wire logic              tx_stb_en,
  input  wire logic              tx_stb_rcvr,
  input  wire ca_stb_pkg::intv_t count_xz,
  input  wire ca_stb_pkg::intv_t tx_stb_intv,
  output logic                   stb_val
);

  import ca_stb_pkg::*;
  import ca_tx_state_pkg::*;

  tx_state_e state;
  tx_state_e state_nxt;
  // Delayed online for edge detect
  logic      online_q;
  logic      online_rise;
  logic      gen_stb;
  // Settle timer after online
  intv_t     settle_timer;
  // Cycles until next strobe
  intv_t     intv_cnt;

  assign online_rise = tx_online & ~online_q;
  assign gen_stb     = (state == TX_GEN_STB);

  // Strobe pulse when the interval counter hits one
  assign stb_val = gen_stb & (intv_cnt == intv_t'(1));

  //////////////////////////////////////////////////
  // Online edge detect and settle timer
  //////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      online_q     <= 1'b0;
      settle_timer <= '0;
    end
    else
    begin
      online_q <= tx_online;
      // Reload on each new online edge
      if (online_rise)
        settle_timer <= count_xz;
      else if (settle_timer != '0)
        settle_timer <= settle_timer - intv_t'(1);
    end
  end

  //////////////////////////////////////////////////
  // Strobe interval counter
  //////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_n)
  begin
    if (!rst_n)
      intv_cnt <= '0;
    else if (online_rise)
      // First strobe comes right after entering generation
      intv_cnt <= intv_t'(1);
    else if (gen_stb)
    begin
      // Reload on a strobe, unless recovery is reported
      if (stb_val && !tx_stb_rcvr)
        intv_cnt <= tx_stb_intv;
      // Zero interval parks the counter and stops strobes
      else if (intv_cnt != '0)
        intv_cnt <= intv_cnt - intv_t'(1);
    end
  end

  //////////////////////////////////////////////////
  // Alignment FSM
  //////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= TX_IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      TX_IDLE:
        if (tx_online)
          state_nxt = TX_ONLINE;
      // Wait for enable and settle expiry
      TX_ONLINE:
        if (tx_stb_en && (settle_timer == '0))
          state_nxt = TX_GEN_STB;
      TX_GEN_STB:
        if (tx_stb_rcvr)
          state_nxt = TX_DONE;
      // Only reset leaves here
      TX_DONE:
        state_nxt = TX_DONE;
      default:
        state_nxt = TX_IDLE;
    endcase
  end

  // Strobes are spaced apart unless the reload is one
  a_stb_gap: assert property (@(posedge com_clk) disable iff (!rst_n)
    (stb_val && !tx_stb_rcvr && !online_rise && (tx_stb_intv != intv_t'(1)))
      |=> !stb_val);

  // Done is sticky
  a_done_sticky: assert property (@(posedge com_clk) disable iff (!rst_n)
    (state == TX_DONE) |=> (state == TX_DONE));

endmodule

`default_nettype wire

//--- hdl/ca_stb_loc_decode.sv
// Strobe location decoder
// Turns the one-hot word and bit selects into a strobe
// bit location inside the channel word, and flags a
// malformed select or a location past the channel width

`timescale 1ns/1ps
`default_nettype none

module ca_stb_loc_decode
#(
  parameter int BITS_PER_CHANNEL = 80
)
(
  input  wire ca_stb_pkg::wd_sel_t  tx_stb_wd_sel,
  input  wire ca_stb_pkg::bit_sel_t tx_stb_bit_sel,
  output ca_stb_pkg::stb_loc_t      stb_loc,
  output logic                      tx_stb_pos_err,
  output logic                      tx_stb_pos_coding_err
);

  import ca_stb_pkg::*;

  // Lowest set word select index
  logic [2:0] word_idx;
  // Highest set bit select index
  logic [5:0] bit_idx;
  stb_loc_t   word_start;
  // Population counts of both selects
  logic [3:0] wd_ones;
  logic [5:0] bit_ones;

  //////////////////////////////////////////////////
  // Select priority encode and location
  //////////////////////////////////////////////////

  always_comb
  begin
    word_idx = '0;
    // Walk down so the lowest set bit wins
    for (int k = NUM_WORDS - 1; k >= 0; k--)
      if (tx_stb_wd_sel[k])
        word_idx = 3'(k);
    bit_idx = '0;
    // Walk up so the highest set bit wins
    for (int k = 0; k < WORD_SPAN; k++)
      if (tx_stb_bit_sel[k])
        bit_idx = 6'(k);
    // Word start plus bit offset
    word_start = stb_loc_t'(word_idx) * stb_loc_t'(WORD_SPAN);
    stb_loc    = word_start + stb_loc_t'(bit_idx);
    // Legal selects decode back to the same word and bit
    if ($onehot(tx_stb_wd_sel) && $onehot(tx_stb_bit_sel))
      a_loc_round_trip: assert (tx_stb_wd_sel[int'(stb_loc) / WORD_SPAN] &&
                                tx_stb_bit_sel[int'(stb_loc) % WORD_SPAN]);
  end

  //////////////////////////////////////////////////
  // Error flags
  //////////////////////////////////////////////////

  always_comb
  begin
    wd_ones = '0;
    for (int k = 0; k < NUM_WORDS; k++)
      wd_ones = wd_ones + 4'(tx_stb_wd_sel[k]);
    bit_ones = '0;
    for (int k = 0; k < WORD_SPAN; k++)
      bit_ones = bit_ones + 6'(tx_stb_bit_sel[k]);
  end

  // Each select must be exactly one-hot
  assign tx_stb_pos_coding_err = (wd_ones != 4'd1) | (bit_ones != 6'd1);

  // Location must fall inside the channel word
  assign tx_stb_pos_err = (int'(stb_loc) >= BITS_PER_CHANNEL);

endmodule

`default_nettype wire

//--- hdl/ca_tx_mux.sv
// TX strobe insertion mux
// One per channel. While strobing is enabled, the bit at
// the strobe location carries the strobe value and all
// other bits pass straight through.

`timescale 1ns/1ps
`default_nettype none

module ca_tx_mux
#(
  parameter int CH_WIDTH = 80
)
(
  input  wire logic [CH_WIDTH-1:0] data_in,
  input  wire ca_stb_pkg::stb_loc_t stb_loc,
  input  wire logic                stb_val,
  input  wire logic                tx_stb_en,
  output logic [CH_WIDTH-1:0]      data_out
);

  // Per-bit hit on the strobe location
  logic [CH_WIDTH-1:0] loc_hit;

  //////////////////////////////////////////////////
  // Location match
  //////////////////////////////////////////////////

  // Out of range location matches nothing
  always_comb
  begin
    for (int i = 0; i < CH_WIDTH; i++)
      loc_hit[i] = (int'(stb_loc) == i);
  end

  //////////////////////////////////////////////////
  // Bit replace
  //////////////////////////////////////////////////

  always_comb
  begin
    data_out = data_in;
    if (tx_stb_en)
    begin
      for (int i = 0; i < CH_WIDTH; i++)
        if (loc_hit[i])
          // Strobe value is zero between strobes
          data_out[i] = stb_val;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ca_tx_strb.sv
// TX channel alignment strobe top
// Splits the wide data bus into channels, decodes the
// strobe position once, runs the strobe control and
// inserts the strobe bit into every channel word

`timescale 1ns/1ps
`default_nettype none

module ca_tx_strb
#(
  parameter int NUM_CHANNELS     = 2,
  parameter int BITS_PER_CHANNEL = 80
)
(
  input  wire logic                                   com_clk,
  input  wire logic                                   rst_n,
  input  wire logic                                   tx_online,
  input  wire logic                                   tx_stb_en,
  input  wire logic                                   tx_stb_rcvr,
  input  wire ca_stb_pkg::intv_t                      count_xz,
  input  wire ca_stb_pkg::intv_t                      tx_stb_intv,
  input  wire ca_stb_pkg::wd_sel_t                    tx_stb_wd_sel,
  input  wire ca_stb_pkg::bit_sel_t                   tx_stb_bit_sel,
  input  wire logic [NUM_CHANNELS*BITS_PER_CHANNEL-1:0] tx_din,
  output wire logic [NUM_CHANNELS*BITS_PER_CHANNEL-1:0] tx_dout,
  output wire logic                                   tx_stb_pos_err,
  output wire logic                                   tx_stb_pos_coding_err
);

  import ca_stb_pkg::*;

  // Shared strobe location, same in every channel
  stb_loc_t stb_loc;
  // Single-cycle strobe pulse
  logic     stb_val;

  //////////////////////////////////////////////////
  // Strobe control
  //////////////////////////////////////////////////

  ca_tx_strb_ctrl u_ctrl
  (
    .com_clk     (com_clk),
    .rst_n       (rst_n),
    .tx_online   (tx_online),
    .tx_stb_en   (tx_stb_en),
    .tx_stb_rcvr (tx_stb_rcvr),
    .count_xz    (count_xz),
    .tx_stb_intv (tx_stb_intv),
    .stb_val     (stb_val)
  );

  // Position decode and error flags
  ca_stb_loc_decode #(.BITS_PER_CHANNEL(BITS_PER_CHANNEL)) u_decode
  (
    .tx_stb_wd_sel         (tx_stb_wd_sel),
    .tx_stb_bit_sel        (tx_stb_bit_sel),
    .stb_loc               (stb_loc),
    .tx_stb_pos_err        (tx_stb_pos_err),
    .tx_stb_pos_coding_err (tx_stb_pos_coding_err)
  );

  //////////////////////////////////////////////////
  // Per-channel insertion muxes
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < NUM_CHANNELS; ch++)
  begin : g_ch
    ca_tx_mux #(.CH_WIDTH(BITS_PER_CHANNEL)) u_mux
    (
      .data_in   (tx_din[ch*BITS_PER_CHANNEL +: BITS_PER_CHANNEL]),
      .stb_loc   (stb_loc),
      .stb_val   (stb_val),
      .tx_stb_en (tx_stb_en),
      .data_out  (tx_dout[ch*BITS_PER_CHANNEL +: BITS_PER_CHANNEL])
    );
  end

endmodule

`default_nettype wire

//--- tests/ca_tx_strb_tb.sv
// TX channel alignment strobe testbench
// Directed tests for pass-through, position error flags,
// strobe insertion after the settle window, strobe spacing,
// recovery and restart after reset

`timescale 1ns/1ps
`default_nettype none

module ca_tx_strb_tb;

  import ca_stb_pkg::*;

  localparam int NUM_CH      = 2;
  localparam int BPC         = 80;
  localparam int DATA_W      = NUM_CH * BPC;
  localparam int STB_TIMEOUT = 64;
  localparam int SEED        = 55092;

  logic              com_clk;
  logic              rst_n;
  logic              tx_online;
  logic              tx_stb_en;
  logic              tx_stb_rcvr;
  intv_t             count_xz;
  intv_t             tx_stb_intv;
  wd_sel_t           tx_stb_wd_sel;
  bit_sel_t          tx_stb_bit_sel;
  logic [DATA_W-1:0] tx_din;
  logic [DATA_W-1:0] tx_dout;
  logic              tx_stb_pos_err;
  logic              tx_stb_pos_coding_err;

  // Strobe bit position inside each channel word
  int strobe_loc;
  // Interval loaded at the next strobe
  int intv_now;

  ca_tx_strb UUT
  (
    .com_clk               (com_clk),
    .rst_n                 (rst_n),
    .tx_online             (tx_online),
    .tx_stb_en             (tx_stb_en),
    .tx_stb_rcvr           (tx_stb_rcvr),
    .count_xz              (count_xz),
    .tx_stb_intv           (tx_stb_intv),
    .tx_stb_wd_sel         (tx_stb_wd_sel),
    .tx_stb_bit_sel        (tx_stb_bit_sel),
    .tx_din                (tx_din),
    .tx_dout               (tx_dout),
    .tx_stb_pos_err        (tx_stb_pos_err),
    .tx_stb_pos_coding_err (tx_stb_pos_coding_err)
  );

  // 4 ns clock
  initial
  begin
    com_clk = 1'b0;
    forever #2 com_clk = ~com_clk;
  end

  //////////////////////////////////////////////////
  // Reporting and compare
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s at %0t ns", what, $time);
    abort_run();
  endtask

  task automatic check_dout(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [DATA_W-1:0] random_din();
    return {$urandom, $urandom, $urandom, $urandom, $urandom};
  endfunction

  // Input word with the strobe bit forced in every channel
  function automatic logic [DATA_W-1:0] insert_strobe(input logic [DATA_W-1:0] din,
                                                      input int loc, input logic stb);
    logic [DATA_W-1:0] v;
    v = din;
    for (int ch = 0; ch < NUM_CH; ch++)
      v[ch*BPC + loc] = stb;
    return v;
  endfunction

  // Rising edge plus fresh data, callers add their own drives after
  task automatic clock_in_data();
    @(posedge com_clk);
    tx_din <= random_din();
  endtask

  // Mid-cycle, all outputs settled
  task automatic wait_sample();
    @(negedge com_clk);
  endtask

  task automatic apply_reset();
    @(posedge com_clk);
    rst_n       <= 1'b0;
    tx_online   <= 1'b0;
    tx_stb_en   <= 1'b0;
    tx_stb_rcvr <= 1'b0;
    repeat (10) @(posedge com_clk);
    rst_n <= 1'b1;
    wait_sample();
  endtask

  task automatic drive_selects(input wd_sel_t wd, input bit_sel_t bs);
    clock_in_data();
    tx_stb_wd_sel  <= wd;
    tx_stb_bit_sel <= bs;
    wait_sample();
  endtask

  // One strobe gap, the interval may change only on its first edge
  task automatic run_gap(input int gap, input int next_intv);
    for (int j = 1; j <= gap; j++)
    begin
      clock_in_data();
      if (j == 1)
        tx_stb_intv <= intv_t'(next_intv);
      wait_sample();
      check_dout(tx_dout, insert_strobe(tx_din, strobe_loc, (j == gap)), "strobe spacing");
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_pass_through();
    for (int i = 0; i < 40; i++)
    begin
      clock_in_data();
      tx_stb_wd_sel  <= wd_sel_t'($urandom);
      tx_stb_bit_sel <= bit_sel_t'({$urandom, $urandom});
      wait_sample();
      check_dout(tx_dout, tx_din, "pass-through with strobing disabled");
    end
  endtask

  task automatic test_error_flags();
    int k;
    int b;
    drive_selects('0, bit_sel_t'(1));
    check_flag(tx_stb_pos_coding_err, 1'b1, "empty word select");
    drive_selects(wd_sel_t'(8'h05), bit_sel_t'(1));
    check_flag(tx_stb_pos_coding_err, 1'b1, "two word select bits");
    drive_selects(wd_sel_t'(1), '0);
    check_flag(tx_stb_pos_coding_err, 1'b1, "empty bit select");
    drive_selects(wd_sel_t'(2), bit_sel_t'(40'h00_0000_0201));
    check_flag(tx_stb_pos_coding_err, 1'b1, "two bit select bits");
    // Edges of the channel word first, then random legal selects
    for (int i = 0; i < 26; i++)
    begin
      k = (i == 0) ? 1 : (i == 1) ? 2 : int'($urandom_range(7, 0));
      b = (i == 0) ? 39 : (i == 1) ? 0 : int'($urandom_range(39, 0));
      drive_selects(wd_sel_t'(1) << k, bit_sel_t'(1) << b);
      check_flag(tx_stb_pos_coding_err, 1'b0, "legal select");
      check_flag(tx_stb_pos_err, (k * WORD_SPAN + b >= BPC), "position range");
    end
  endtask

  task automatic test_strobe_insertion();
    int  k;
    int  b;
    int  n;
    int  cycles;
    logic found;
    logic seen;
    k = int'($urandom_range(1, 0));
    b = int'($urandom_range(39, 0));
    n = int'($urandom_range(12, 4));
    strobe_loc = k * WORD_SPAN + b;
    intv_now   = 5;
    clock_in_data();
    tx_stb_wd_sel  <= wd_sel_t'(1) << k;
    tx_stb_bit_sel <= bit_sel_t'(1) << b;
    count_xz       <= intv_t'(n);
    tx_stb_intv    <= intv_t'(intv_now);
    tx_stb_en      <= 1'b1;
    wait_sample();
    check_dout(tx_dout, insert_strobe(tx_din, strobe_loc, 1'b0), "selected bit before online");
    clock_in_data();
    tx_online <= 1'b1;
    wait_sample();
    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < STB_TIMEOUT)
    begin
      clock_in_data();
      wait_sample();
      cycles++;
      seen = tx_dout[strobe_loc];
      // Same strobe in every channel, other bits untouched
      check_dout(tx_dout, insert_strobe(tx_din, strobe_loc, seen), "strobe insertion");
      found = seen;
    end
    if (!found)
      report_timeout("first strobe after online");
    check_flag(logic'(cycles > n), 1'b1, "strobe inside settle window");
  endtask

  task automatic test_intervals();
    int next_intv;
    for (int i = 0; i < 6; i++)
    begin
      next_intv = int'($urandom_range(20, 1));
      run_gap(intv_now, next_intv);
      intv_now = next_intv;
    end
  endtask

  task automatic test_recovery();
    // Long reload so no strobe races the recovery
    run_gap(intv_now, 10);
    clock_in_data();
    tx_stb_rcvr <= 1'b1;
    wait_sample();
    check_dout(tx_dout, insert_strobe(tx_din, strobe_loc, 1'b0), "strobe after recovery");
    for (int i = 0; i < 90; i++)
    begin
      clock_in_data();
      if (i == 60)
        tx_stb_rcvr <= 1'b0;
      wait_sample();
      check_dout(tx_dout, insert_strobe(tx_din, strobe_loc, 1'b0), "strobe after recovery");
    end
  endtask

  // Reset, then a new online edge brings strobes back
  task automatic test_restart();
    apply_reset();
    test_strobe_insertion();
    run_gap(intv_now, 3);
    run_gap(3, 3);
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst_n          <= 1'b0;
    tx_online      <= 1'b0;
    tx_stb_en      <= 1'b0;
    tx_stb_rcvr    <= 1'b0;
    count_xz       <= '0;
    tx_stb_intv    <= '0;
    tx_stb_wd_sel  <= wd_sel_t'(1);
    tx_stb_bit_sel <= bit_sel_t'(1);
    tx_din         <= '0;
    apply_reset();
    test_pass_through();
    test_error_flags();
    test_strobe_insertion();
    test_intervals();
    test_recovery();
    test_restart();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- ca_tx_strb.f
hdl/ca_stb_pkg.sv
hdl/ca_tx_state_pkg.sv
hdl/ca_tx_strb_ctrl.sv
hdl/ca_stb_loc_decode.sv
hdl/ca_tx_mux.sv
hdl/ca_tx_strb.sv
tests/ca_tx_strb_tb.sv

//--- Makefile
# Verilator build and run for the TX alignment strobe block

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= ca_tx_strb_tb
FILELIST  ?= ca_tx_strb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the run prints the pass message
test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
